/* filelist.f */
cpuPkg.sv
fwdIf.sv
pipeReg.sv
fetchStage.sv
instDecode.sv
hazardUnit.sv
regFile.sv
alu.sv
cpuTop.sv
tbCpu.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f filelist.f --top-module tbCpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VtbCpu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

/* tbCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tbCpu;
    import cpuPkg::*;

    localparam logic [31:0] resetPc = 32'hbfc0_0000;
    localparam int resetCycles = 8;
    localparam int instWords = 128;
    localparam int dataWords = 64;
    localparam int subSlot = 96;
    // about 32 instructions at up to 3 cycles each plus reset, fill and drain
    localparam int maxCycles = 400;

    logic clk = 1'b0;
    logic resetn = 1'b0;
    logic [31:0] instSramAddr;
    logic [31:0] instSramRdata = '0;
    logic dataSramEn;
    logic [3:0] dataSramWen;
    logic [31:0] dataSramAddr;
    logic [31:0] dataSramWdata;
    logic [31:0] dataSramRdata = '0;
    logic [31:0] debugWbPc;
    logic debugWbRfWen;
    logic [4:0] debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [instWords];
    logic [31:0] dmem [dataWords];
    logic [31:0] memModel [dataWords];
    logic [31:0] gpr [32];
    logic [31:0] instAddrQ;
    logic [31:0] dataReadQ;
    int seed;
    int slot;
    string testName;

    // expected write-back trace in retire order
    logic [31:0] expPc [$];
    logic [4:0] expReg [$];
    logic [31:0] expData [$];
    string expTest [$];
    logic [31:0] expStoreAddr [$];
    logic [31:0] expStoreData [$];
    string expStoreTest [$];
    int expIdx = 0;
    int storeIdx = 0;
    int cycleCount = 0;
    int postReset = 0;

    cpuTop #(.resetPc(resetPc)) u_dut (
        .clk,
        .resetn,
        .instSramAddr,
        .instSramRdata,
        .dataSramEn,
        .dataSramWen,
        .dataSramAddr,
        .dataSramWdata,
        .dataSramRdata,
        .debugWbPc,
        .debugWbRfWen,
        .debugWbRfWnum,
        .debugWbRfWdata
    );

    always #20 clk = ~clk;

    function automatic logic [6:0] instIndex(logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - resetPc;
        return offset[8:2];
    endfunction

    // sram models take the address on the rising edge and drive data on the falling edge
    always @(posedge clk)
        instAddrQ <= instSramAddr;

    always @(negedge clk)
        instSramRdata <= imem[instIndex(instAddrQ)];

    always @(posedge clk)
    begin
        if (dataSramEn)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (dataSramWen[b])
                    dmem[dataSramAddr[7:2]][8*b +: 8] <= dataSramWdata[8*b +: 8];
            end
            dataReadQ <= dmem[dataSramAddr[7:2]];
        end
    end

    always @(negedge clk)
        dataSramRdata <= dataReadQ;

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportValue(input string test, input string what,
        input logic [31:0] expected, input logic [31:0] actual);
        reportFailure($sformatf("Error in test %s: %s expected 0x%08h, actual 0x%08h",
            test, what, expected, actual));
    endtask

    function automatic logic [31:0] sext(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] rType(logic [5:0] fn, int rd, int rs, int rt, int sa);
        return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, int rt, int rs, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jType(logic [5:0] op, logic [31:0] dest);
        return {op, dest[27:2]};
    endfunction

    function automatic logic [31:0] slotPc(int s);
        return resetPc + 32'(s * 4);
    endfunction

    // offset counts words from the delay slot
    function automatic logic [15:0] branchOffset(int from, int to);
        return 16'(to - from - 1);
    endfunction

    function automatic logic [31:0] loadWord(logic [31:0] addr);
        return memModel[addr[7:2]];
    endfunction

    task automatic place(input logic [31:0] word);
        imem[7'(slot)] = word;
        slot++;
    endtask

    task automatic retire(input logic [31:0] word, input int rd, input logic [31:0] value);
        expPc.push_back(slotPc(slot));
        expReg.push_back(5'(rd));
        expData.push_back(value);
        expTest.push_back(testName);
        gpr[5'(rd)] = value;
        place(word);
    endtask

    task automatic storeWord(input int rt, input int rs, input logic [15:0] imm);
        logic [31:0] addr;
        addr = gpr[5'(rs)] + sext(imm);
        expStoreAddr.push_back(addr);
        expStoreData.push_back(gpr[5'(rt)]);
        expStoreTest.push_back(testName);
        memModel[addr[7:2]] = gpr[5'(rt)];
        place(iType(opSw, rt, rs, imm));
    endtask

    task automatic fillMemories();
        for (int i = 0; i < instWords; i++)
            imem[7'(i)] = {6'h3f, 26'(i)};
        for (int i = 0; i < dataWords; i++)
            dmem[6'(i)] = 32'hd000_0000 | 32'(i * 4);
        for (int i = 8; i < 12; i++)
            dmem[6'(i)] = $random(seed);
        for (int i = 0; i < dataWords; i++)
            memModel[6'(i)] = dmem[6'(i)];
        for (int i = 0; i < 32; i++)
            gpr[5'(i)] = '0;
    endtask

    task automatic buildProgram();
        int retSlot;
        slot = 0;

        testName = "alu chain";
        retire(iType(opAddiu, 1, 0, 16'h1234), 1, gpr[0] + sext(16'h1234));
        retire(iType(opLui, 2, 0, 16'h8765), 2, {16'h8765, 16'h0000});
        retire(rType(fnAddu, 3, 2, 1, 0), 3, gpr[2] + gpr[1]);
        retire(rType(fnSubu, 4, 3, 1, 0), 4, gpr[3] - gpr[1]);
        retire(rType(fnAnd, 5, 4, 3, 0), 5, gpr[4] & gpr[3]);
        retire(rType(fnOr, 6, 5, 1, 0), 6, gpr[5] | gpr[1]);
        retire(rType(fnSlt, 7, 6, 1, 0), 7, {31'b0, $signed(gpr[6]) < $signed(gpr[1])});
        retire(rType(fnSll, 8, 0, 7, 4), 8, gpr[7] << 4);

        testName = "load use";
        retire(iType(opAddiu, 9, 0, 16'h0020), 9, gpr[0] + sext(16'h0020));
        retire(iType(opLw, 10, 9, 16'h0004), 10, loadWord(gpr[9] + sext(16'h0004)));
        retire(rType(fnAddu, 11, 10, 8, 0), 11, gpr[10] + gpr[8]);

        testName = "store load";
        retire(rType(fnAddu, 12, 11, 3, 0), 12, gpr[11] + gpr[3]);
        storeWord(12, 9, 16'h0020);
        retire(iType(opLw, 13, 9, 16'h0020), 13, loadWord(gpr[9] + sext(16'h0020)));
        retire(iType(opLw, 14, 9, 16'h0000), 14, loadWord(gpr[9]));
        retire(iType(opLw, 15, 9, 16'h0008), 15, loadWord(gpr[9] + sext(16'h0008)));
        retire(rType(fnSubu, 16, 15, 14, 0), 16, gpr[15] - gpr[14]);

        testName = "branch";
        retire(iType(opAddiu, 17, 0, 16'h0005), 17, gpr[0] + sext(16'h0005));
        retire(iType(opAddiu, 18, 0, 16'h0005), 18, gpr[0] + sext(16'h0005));
        // equal operands make beq skip one instruction
        place(iType(opBeq, 18, 17, branchOffset(slot, slot + 3)));
        retire(iType(opAddiu, 19, 17, 16'h0001), 19, gpr[17] + sext(16'h0001));
        place(iType(opAddiu, 20, 0, 16'h0777));
        retire(iType(opAddiu, 21, 17, 16'h0000), 21, gpr[17]);
        // bne falls through on equal operands
        place(iType(opBne, 18, 21, branchOffset(slot, slot + 5)));
        retire(iType(opAddiu, 22, 21, 16'h0002), 22, gpr[21] + sext(16'h0002));
        retire(iType(opAddiu, 23, 22, 16'h0003), 23, gpr[22] + sext(16'h0003));

        testName = "jal jr";
        retire(jType(opJal, slotPc(subSlot)), 31, slotPc(slot) + 32'd8);
        retire(iType(opAddiu, 25, 0, 16'h0055), 25, gpr[0] + sext(16'h0055));
        retSlot = slot;
        slot = subSlot;
        retire(iType(opAddiu, 26, 25, 16'h0001), 26, gpr[25] + sext(16'h0001));
        place(rType(fnJr, 0, 31, 0, 0));
        retire(iType(opAddiu, 27, 26, 16'h0001), 27, gpr[26] + sext(16'h0001));
        place(iType(opAddiu, 20, 0, 16'h0777));
        slot = retSlot;
        retire(rType(fnAddu, 28, 27, 31, 0), 28, gpr[27] + gpr[31]);

        // spin here with a fill word in the delay slot
        place(iType(opBeq, 0, 0, branchOffset(slot, slot)));
    endtask

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > maxCycles)
            reportFailure($sformatf("timeout: the run did not finish in %0d cycles", maxCycles));
        else
        begin
            // the first edge only loads the reset values
            if (cycleCount > 1 && (!resetn || postReset < 4))
            begin
                assert (!debugWbRfWen)
                    else reportFailure("register write-back active during or right after reset");
                assert (!dataSramEn)
                    else reportFailure("data memory enabled during or right after reset");
            end
            if (cycleCount > 1 && (!resetn || postReset == 0))
                assert (instSramAddr == resetPc)
                    else reportValue("reset", "fetch address", resetPc, instSramAddr);
            if (resetn)
                postReset++;
        end
    end

    always @(posedge clk)
    begin
        if (debugWbRfWen)
        begin
            if (expIdx >= expPc.size())
                reportFailure("a register write-back came after the expected trace ended");
            else
            begin
                assert (debugWbPc == expPc[expIdx])
                    else reportValue(expTest[expIdx], "pc", expPc[expIdx], debugWbPc);
                assert (debugWbRfWnum == expReg[expIdx])
                    else reportValue(expTest[expIdx], "register", 32'(expReg[expIdx]),
                        32'(debugWbRfWnum));
                assert (debugWbRfWdata == expData[expIdx])
                    else reportValue(expTest[expIdx], "write data", expData[expIdx],
                        debugWbRfWdata);
                expIdx++;
            end
        end
    end

    always @(posedge clk)
    begin
        if (dataSramEn && dataSramWen != 4'h0)
        begin
            if (storeIdx >= expStoreAddr.size())
                reportFailure("the data memory saw a store that the program does not hold");
            else
            begin
                assert (dataSramWen == 4'hf)
                    else reportValue(expStoreTest[storeIdx], "byte enables", 32'hf,
                        32'(dataSramWen));
                assert (dataSramAddr == expStoreAddr[storeIdx])
                    else reportValue(expStoreTest[storeIdx], "store address",
                        expStoreAddr[storeIdx], dataSramAddr);
                assert (dataSramWdata == expStoreData[storeIdx])
                    else reportValue(expStoreTest[storeIdx], "store data",
                        expStoreData[storeIdx], dataSramWdata);
                storeIdx++;
            end
        end
    end

    initial
    begin
        seed = 29795;
        fillMemories();
        buildProgram();
        repeat (resetCycles) @(negedge clk);
        resetn = 1'b1;
        while (expIdx < expPc.size())
            @(negedge clk);
        // let the final loop spin to catch late write-backs
        repeat (8) @(negedge clk);
        if (storeIdx != expStoreAddr.size())
            reportFailure("not every expected store was seen");
        else
        begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTop #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = 32'hbfc0_0000
) (
    input  logic clk,
    input  logic resetn,
    output logic [cpuPkg::dataWidth-1:0] instSramAddr,
    input  logic [cpuPkg::dataWidth-1:0] instSramRdata,
    output logic dataSramEn,
    output logic [3:0] dataSramWen,
    output logic [cpuPkg::dataWidth-1:0] dataSramAddr,
    output logic [cpuPkg::dataWidth-1:0] dataSramWdata,
    input  logic [cpuPkg::dataWidth-1:0] dataSramRdata,
    output logic [cpuPkg::dataWidth-1:0] debugWbPc,
    output logic debugWbRfWen,
    output logic [cpuPkg::regAddrWidth-1:0] debugWbRfWnum,
    output logic [cpuPkg::dataWidth-1:0] debugWbRfWdata
);
    import cpuPkg::*;

    logic [dataWidth-1:0] decInst;
    logic [dataWidth-1:0] decPc;
    logic decValid;
    logic decReadyGo;
    logic decAllowin;
    decCtrl_t ctrl;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic useRs;
    logic useRt;
    logic [1:0] fwdSel1;
    logic [1:0] fwdSel2;
    logic hazStall;
    logic [dataWidth-1:0] rfData1;
    logic [dataWidth-1:0] rfData2;
    logic [dataWidth-1:0] rsVal;
    logic [dataWidth-1:0] rtVal;
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] pcPlus4;
    logic brTaken;
    logic [dataWidth-1:0] target;
    idEx_t idExIn;
    idEx_t idEx;
    logic exValid;
    logic exAllowin;
    logic [dataWidth-1:0] aluResult;
    exMa_t exMaIn;
    exMa_t exMa;
    logic maValid;
    logic maAllowin;
    maWb_t maWbIn;
    maWb_t maWb;
    logic wbValid;
    logic wbAllowin;
    logic [dataWidth-1:0] wbData;

    fwdIf exFwd();
    fwdIf maFwd();
    fwdIf wbFwd();

    function automatic logic [dataWidth-1:0] pickOperand(
        input logic [1:0] sel,
        input logic [dataWidth-1:0] rfVal,
        input logic [dataWidth-1:0] exVal,
        input logic [dataWidth-1:0] maVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            fwdEx: return exVal;
            fwdMa: return maVal;
            fwdWb: return wbVal;
            default: return rfVal;
        endcase
    endfunction

    fetchStage #(.resetPc(resetPc)) u_fetch (
        .clk,
        .resetn,
        .instSramRdata,
        .stall(!decAllowin),
        .redirect(decValid && brTaken),
        .target,
        .instSramAddr,
        .inst(decInst),
        .pc(decPc),
        .valid(decValid)
    );

    assign decReadyGo = !hazStall;
    assign decAllowin = !decValid || (decReadyGo && exAllowin);

    instDecode u_dec (
        .inst(decInst),
        .ctrl
    );

    assign rs = decInst[25:21];
    assign rt = decInst[20:16];
    assign rd = decInst[15:11];
    assign useRs = !(ctrl.useShamt || ctrl.link || ctrl.aluOp == aluLui);
    assign useRt = ctrl.memWrite || !(ctrl.useImm || ctrl.link || ctrl.isJr);

    regFile u_rf (
        .clk,
        .raddr1(rs),
        .raddr2(rt),
        .wen(debugWbRfWen),
        .waddr(maWb.waddr),
        .wdata(wbData),
        .rdata1(rfData1),
        .rdata2(rfData2)
    );

    hazardUnit u_haz (
        .rs,
        .rt,
        .useRs,
        .useRt,
        .exFwd,
        .maFwd,
        .wbFwd,
        .fwdSel1,
        .fwdSel2,
        .stall(hazStall)
    );

    assign rsVal = pickOperand(fwdSel1, rfData1, exFwd.data, maFwd.data, wbFwd.data);
    assign rtVal = pickOperand(fwdSel2, rfData2, exFwd.data, maFwd.data, wbFwd.data);
    assign imm = {{(dataWidth-16){ctrl.signExt && decInst[15]}}, decInst[15:0]};
    assign pcPlus4 = decPc + dataWidth'(4);

    // branch resolves here while the delay slot is already in fetch
    assign brTaken = (ctrl.isBeq && rsVal == rtVal) || (ctrl.isBne && rsVal != rtVal)
        || ctrl.isJal || ctrl.isJr;
    assign target = ctrl.isJr ? rsVal
        : ctrl.isJal ? {pcPlus4[31:28], decInst[25:0], 2'b00}
        : pcPlus4 + {imm[dataWidth-3:0], 2'b00};

    always_comb
    begin
        idExIn.pc = decPc;
        idExIn.aluOp = ctrl.aluOp;
        if (ctrl.link)
            idExIn.src1 = decPc + dataWidth'(8);
        else if (ctrl.useShamt)
            idExIn.src1 = {{(dataWidth-5){1'b0}}, decInst[10:6]};
        else
            idExIn.src1 = rsVal;
        if (ctrl.link)
            idExIn.src2 = '0;
        else
            idExIn.src2 = ctrl.useImm ? imm : rtVal;
        idExIn.storeData = rtVal;
        if (ctrl.link)
            idExIn.waddr = 5'd31;
        else
            idExIn.waddr = ctrl.dstRt ? rt : rd;
        idExIn.regWrite = ctrl.regWrite;
        idExIn.memRead = ctrl.memRead;
        idExIn.memWrite = ctrl.memWrite;
    end

    // a stalled decode leaves a bubble in execute
    pipeReg #(.payload_t(idEx_t)) u_exReg (
        .clk,
        .resetn,
        .inValid(decValid && decReadyGo),
        .inData(idExIn),
        .nextAllowin(maAllowin),
        .allowin(exAllowin),
        .outValid(exValid),
        .outData(idEx)
    );

    alu u_alu (
        .aluOp(idEx.aluOp),
        .src1(idEx.src1),
        .src2(idEx.src2),
        .result(aluResult)
    );

    assign exMaIn = '{pc: idEx.pc, result: aluResult, storeData: idEx.storeData,
        waddr: idEx.waddr, regWrite: idEx.regWrite, memRead: idEx.memRead,
        memWrite: idEx.memWrite};

    pipeReg #(.payload_t(exMa_t)) u_maReg (
        .clk,
        .resetn,
        .inValid(exValid),
        .inData(exMaIn),
        .nextAllowin(wbAllowin),
        .allowin(maAllowin),
        .outValid(maValid),
        .outData(exMa)
    );

    assign dataSramEn = maValid && (exMa.memRead || exMa.memWrite);
    assign dataSramWen = {4{maValid && exMa.memWrite}};
    assign dataSramAddr = exMa.result;
    assign dataSramWdata = exMa.storeData;

    assign maWbIn = '{pc: exMa.pc, result: exMa.result, waddr: exMa.waddr,
        regWrite: exMa.regWrite, memRead: exMa.memRead};

    // write-back never pushes back
    pipeReg #(.payload_t(maWb_t)) u_wbReg (
        .clk,
        .resetn,
        .inValid(maValid),
        .inData(maWbIn),
        .nextAllowin(1'b1),
        .allowin(wbAllowin),
        .outValid(wbValid),
        .outData(maWb)
    );

    assign wbData = maWb.memRead ? dataSramRdata : maWb.result;

    assign debugWbPc = maWb.pc;
    assign debugWbRfWen = wbValid && maWb.regWrite;
    assign debugWbRfWnum = maWb.waddr;
    assign debugWbRfWdata = wbData;

    assign exFwd.valid = exValid;
    assign exFwd.regWrite = idEx.regWrite;
    assign exFwd.waddr = idEx.waddr;
    assign exFwd.data = aluResult;
    assign exFwd.memRead = idEx.memRead;

    assign maFwd.valid = maValid;
    assign maFwd.regWrite = exMa.regWrite;
    assign maFwd.waddr = exMa.waddr;
    assign maFwd.data = exMa.result;
    assign maFwd.memRead = exMa.memRead;

    assign wbFwd.valid = wbValid;
    assign wbFwd.regWrite = maWb.regWrite;
    assign wbFwd.waddr = maWb.waddr;
    assign wbFwd.data = wbData;
    assign wbFwd.memRead = maWb.memRead;

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  cpuPkg::aluOp_e aluOp,
    input  logic [cpuPkg::dataWidth-1:0] src1,
    input  logic [cpuPkg::dataWidth-1:0] src2,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    localparam int half = dataWidth / 2;

    always_comb
    begin
        case (aluOp)
            aluAdd: result = src1 + src2;
            aluSub: result = src1 - src2;
            aluAnd: result = src1 & src2;
            aluOr: result = src1 | src2;
            aluSlt: result = {{(dataWidth-1){1'b0}}, $signed(src1) < $signed(src2)};
            // shamt arrives on src1
            aluSll: result = src2 << src1[4:0];
            aluLui: result = {src2[half-1:0], {half{1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic clk,
    input  logic [cpuPkg::regAddrWidth-1:0] raddr1,
    input  logic [cpuPkg::regAddrWidth-1:0] raddr2,
    input  logic wen,
    input  logic [cpuPkg::regAddrWidth-1:0] waddr,
    input  logic [cpuPkg::dataWidth-1:0] wdata,
    output logic [cpuPkg::dataWidth-1:0] rdata1,
    output logic [cpuPkg::dataWidth-1:0] rdata2
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [1:31];

    always_ff @(posedge clk)
    begin
        if (wen && waddr != '0)
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  logic [cpuPkg::regAddrWidth-1:0] rs,
    input  logic [cpuPkg::regAddrWidth-1:0] rt,
    input  logic useRs,
    input  logic useRt,
    fwdIf.sink exFwd,
    fwdIf.sink maFwd,
    fwdIf.sink wbFwd,
    output logic [1:0] fwdSel1,
    output logic [1:0] fwdSel2,
    output logic stall
);
    import cpuPkg::*;

    logic [regAddrWidth-1:0] srcReg [2];
    logic [1:0] srcUsed;
    logic [1:0] srcSel [2];
    logic [1:0] srcWait;

    assign srcReg[0] = rs;
    assign srcReg[1] = rt;
    assign srcUsed = {useRt, useRs};

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            srcSel[i] = fwdRf;
            srcWait[i] = 1'b0;
            // youngest writer wins
            if (srcUsed[i] && srcReg[i] != '0)
            begin
                if (exFwd.valid && exFwd.regWrite && exFwd.waddr == srcReg[i])
                begin
                    srcSel[i] = fwdEx;
                    srcWait[i] = exFwd.memRead;
                end
                else if (maFwd.valid && maFwd.regWrite && maFwd.waddr == srcReg[i])
                begin
                    srcSel[i] = fwdMa;
                    // load data only shows up in write-back
                    srcWait[i] = maFwd.memRead;
                end
                else if (wbFwd.valid && wbFwd.regWrite && wbFwd.waddr == srcReg[i])
                    srcSel[i] = fwdWb;
            end
        end
    end

    assign fwdSel1 = srcSel[0];
    assign fwdSel2 = srcSel[1];
    assign stall = |srcWait;

endmodule

`default_nettype wire

/* instDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module instDecode (
    input  logic [cpuPkg::dataWidth-1:0] inst,
    output cpuPkg::decCtrl_t ctrl
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign funct = inst[5:0];

    always_comb
    begin
        // unknown encodings fall through as a nop
        ctrl = '0;
        case (opcode)
            opSpecial:
            begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnSll:
                    begin
                        ctrl.aluOp = aluSll;
                        ctrl.useShamt = 1'b1;
                    end
                    fnJr:
                    begin
                        ctrl.regWrite = 1'b0;
                        ctrl.isJr = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.signExt = 1'b1;
                ctrl.dstRt = 1'b1;
            end
            opLui:
            begin
                ctrl.aluOp = aluLui;
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.dstRt = 1'b1;
            end
            opLw:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.signExt = 1'b1;
                ctrl.dstRt = 1'b1;
            end
            opSw:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.signExt = 1'b1;
            end
            opBeq:
            begin
                ctrl.isBeq = 1'b1;
                ctrl.signExt = 1'b1;
            end
            opBne:
            begin
                ctrl.isBne = 1'b1;
                ctrl.signExt = 1'b1;
            end
            opJal:
            begin
                ctrl.isJal = 1'b1;
                ctrl.link = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = 32'hbfc0_0000
) (
    input  logic clk,
    input  logic resetn,
    input  logic [cpuPkg::dataWidth-1:0] instSramRdata,
    input  logic stall,
    input  logic redirect,
    input  logic [cpuPkg::dataWidth-1:0] target,
    output logic [cpuPkg::dataWidth-1:0] instSramAddr,
    output logic [cpuPkg::dataWidth-1:0] inst,
    output logic [cpuPkg::dataWidth-1:0] pc,
    output logic valid
);
    import cpuPkg::*;

    logic [dataWidth-1:0] fetchPc;
    logic [dataWidth-1:0] holdInst;
    logic stalledLast;

    assign instSramAddr = fetchPc;

    // sram output already moved on after the first stalled cycle
    assign inst = stalledLast ? holdInst : instSramRdata;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fetchPc <= resetPc;
            valid <= 1'b0;
            stalledLast <= 1'b0;
        end
        else
        begin
            stalledLast <= stall;
            if (!stall)
            begin
                fetchPc <= redirect ? target : fetchPc + dataWidth'(4);
                valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            pc <= fetchPc;
        if (!stalledLast)
            holdInst <= instSramRdata;
    end

endmodule

`default_nettype wire

/* pipeReg.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeReg #(
    parameter type payload_t = logic
) (
    input  logic clk,
    input  logic resetn,
    input  logic inValid,
    input  payload_t inData,
    input  logic nextAllowin,
    output logic allowin,
    output logic outValid,
    output payload_t outData
);

    // readyGo is high here, so empty or draining means room
    assign allowin = !outValid || nextAllowin;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            outValid <= 1'b0;
        else if (allowin)
            outValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid && allowin)
            outData <= inData;
    end

endmodule

`default_nettype wire

/* fwdIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface fwdIf;
    import cpuPkg::*;

    logic valid;
    logic regWrite;
    logic [regAddrWidth-1:0] waddr;
    logic [dataWidth-1:0] data;
    // data is not final yet when this is set
    logic memRead;

    modport source (output valid, regWrite, waddr, data, memRead);
    modport sink (input valid, regWrite, waddr, data, memRead);

endinterface

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opJal = 6'b000011;
    localparam logic [5:0] opBeq = 6'b000100;
    localparam logic [5:0] opBne = 6'b000101;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opLui = 6'b001111;
    localparam logic [5:0] opLw = 6'b100011;
    localparam logic [5:0] opSw = 6'b101011;

    // function field under opSpecial
    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnJr = 6'b001000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr = 6'b100101;
    localparam logic [5:0] fnSlt = 6'b101010;

    // decode operand source
    localparam logic [1:0] fwdRf = 2'd0;
    localparam logic [1:0] fwdEx = 2'd1;
    localparam logic [1:0] fwdMa = 2'd2;
    localparam logic [1:0] fwdWb = 2'd3;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOp_e;

    typedef struct packed {
        aluOp_e aluOp;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic useImm;
        logic signExt;
        logic useShamt;
        logic dstRt;
        logic link;
        logic isBeq;
        logic isBne;
        logic isJal;
        logic isJr;
    } decCtrl_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        aluOp_e aluOp;
        logic [dataWidth-1:0] src1;
        logic [dataWidth-1:0] src2;
        logic [dataWidth-1:0] storeData;
        logic [regAddrWidth-1:0] waddr;
        logic regWrite;
        logic memRead;
        logic memWrite;
    } idEx_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] storeData;
        logic [regAddrWidth-1:0] waddr;
        logic regWrite;
        logic memRead;
        logic memWrite;
    } exMa_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] result;
        logic [regAddrWidth-1:0] waddr;
        logic regWrite;
        logic memRead;
    } maWb_t;

endpackage

`default_nettype wire
